// File: Bender.yml
package:
  name: pool_unit

sources:
  - files:
      - source/pool_pkg.sv
      - source/pool_ctrl.sv
      - source/max_array.sv
      - source/pool_core.sv
      - source/ofm_wr_arbiter.sv
      - source/pool_top.sv
  - target: test
    files:
      - tb/pool_properties.sv
      - tb/pool_tb.sv

// File: source/max_array.sv
`timescale 1ns/1ps

// Lane-wise running maximum over the rows of one output point

module max_array (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_row,
    input  logic               first_nbr,
    input  pool_pkg::act_row_t row,
    output pool_pkg::act_row_t max_row
);
    import pool_pkg::*;

    // ==========================================================
    // One compare and register per lane
    // ==========================================================

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic [ACT_WIDTH-1:0] lane_in;
        logic [ACT_WIDTH-1:0] lane_q;
        logic                 take_in;

        assign lane_in = row[l];

        // First row of a point replaces the old maximum
        assign take_in = first_nbr | (lane_in > lane_q);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                lane_q <= '0;
            end else if (load_row && take_in) begin
                lane_q <= lane_in;
            end
        end

        assign max_row[l] = lane_q;
    end

endmodule

// File: source/ofm_wr_arbiter.sv
`timescale 1ns/1ps

// Round-robin write arbiter
// Merges the core write requests onto the single output write port

module ofm_wr_arbiter (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [pool_pkg::NUM_CORE-1:0]             req_vld,
    input  pool_pkg::ofm_wr_t [pool_pkg::NUM_CORE-1:0] req,
    output logic [pool_pkg::NUM_CORE-1:0]             req_rdy,
    output logic                                      ofm_wr_vld,
    output pool_pkg::ofm_wr_t                         ofm_wr,
    input  logic                                      ofm_wr_rdy
);
    import pool_pkg::*;

    logic [CORE_SEL_WIDTH-1:0] last_sel;
    logic [CORE_SEL_WIDTH-1:0] lock_sel;
    logic                      locked;
    logic [CORE_SEL_WIDTH-1:0] cand;
    logic [CORE_SEL_WIDTH-1:0] rr_sel;
    logic                      rr_hit;
    logic [CORE_SEL_WIDTH-1:0] sel;

    // ==========================================================
    // Grant selection
    // ==========================================================

    // Search starts at the core after the last one served
    always_comb begin
        rr_sel = last_sel;
        rr_hit = 1'b0;
        cand   = last_sel;
        for (int i = 1; i <= NUM_CORE; i++) begin
            cand = CORE_SEL_WIDTH'((int'(last_sel) + i) % NUM_CORE);
            if (!rr_hit && req_vld[cand]) begin
                rr_sel = cand;
                rr_hit = 1'b1;
            end
        end
    end

    // A stalled offer keeps its grant
    assign sel        = locked ? lock_sel : rr_sel;
    assign ofm_wr_vld = req_vld[sel];
    assign ofm_wr     = req[sel];

    always_comb begin
        for (int i = 0; i < NUM_CORE; i++) begin
            req_rdy[i] = ofm_wr_rdy & (sel == CORE_SEL_WIDTH'(i));
        end
    end

    // ==========================================================
    // Pointer and lock
    // ==========================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Last served is the top core, so core 0 goes first
            last_sel <= CORE_SEL_WIDTH'(NUM_CORE - 1);
            lock_sel <= '0;
            locked   <= 1'b0;
        end else begin
            locked   <= ofm_wr_vld & ~ofm_wr_rdy;
            lock_sel <= sel;
            if (ofm_wr_vld && ofm_wr_rdy) begin
                last_sel <= sel;
            end
        end
    end

endmodule

// File: source/pool_core.sv
`timescale 1ns/1ps

// One max-pooling core
// Sequencer plus its lane-wise max datapath

module pool_core (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_vld,
    input  pool_pkg::pool_cfg_t            cfg,
    output logic                           cfg_rdy,
    input  logic                           map_vld,
    input  logic [pool_pkg::IDX_WIDTH-1:0] map_idx,
    output logic                           map_rdy,
    output logic                           rd_addr_vld,
    output logic [pool_pkg::IDX_WIDTH-1:0] rd_addr,
    input  logic                           rd_addr_rdy,
    input  logic                           rd_dat_vld,
    input  pool_pkg::act_row_t             rd_dat,
    output logic                           rd_dat_rdy,
    output logic                           wr_vld,
    output pool_pkg::ofm_wr_t              wr,
    input  logic                           wr_rdy
);
    import pool_pkg::*;

    logic     first_nbr;
    logic     load_row;
    act_row_t max_row;

    pool_ctrl pool_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_vld     (cfg_vld),
        .cfg         (cfg),
        .cfg_rdy     (cfg_rdy),
        .map_vld     (map_vld),
        .map_idx     (map_idx),
        .map_rdy     (map_rdy),
        .rd_addr_vld (rd_addr_vld),
        .rd_addr     (rd_addr),
        .rd_addr_rdy (rd_addr_rdy),
        .rd_dat_vld  (rd_dat_vld),
        .rd_dat_rdy  (rd_dat_rdy),
        .first_nbr   (first_nbr),
        .load_row    (load_row),
        .max_row     (max_row),
        .wr_vld      (wr_vld),
        .wr          (wr),
        .wr_rdy      (wr_rdy)
    );

    // Row data lands here on each read data transfer
    max_array max_array_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_row  (load_row),
        .first_nbr (first_nbr),
        .row       (rd_dat),
        .max_row   (max_row)
    );

endmodule

// File: source/pool_ctrl.sv
`timescale 1ns/1ps

// Pooling core sequencer
// Counts points and neighbours, drives the map, read and write handshakes

module pool_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_vld,
    input  pool_pkg::pool_cfg_t            cfg,
    output logic                           cfg_rdy,
    input  logic                           map_vld,
    input  logic [pool_pkg::IDX_WIDTH-1:0] map_idx,
    output logic                           map_rdy,
    output logic                           rd_addr_vld,
    output logic [pool_pkg::IDX_WIDTH-1:0] rd_addr,
    input  logic                           rd_addr_rdy,
    input  logic                           rd_dat_vld,
    output logic                           rd_dat_rdy,
    output logic                           first_nbr,
    output logic                           load_row,
    input  pool_pkg::act_row_t             max_row,
    output logic                           wr_vld,
    output pool_pkg::ofm_wr_t              wr,
    input  logic                           wr_rdy
);
    import pool_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_IDX,
        ST_DAT,
        ST_WR
    } state_t;

    state_t               state;
    pool_cfg_t            cfg_q;
    logic [K_WIDTH-1:0]   nbr_cnt;
    logic [IDX_WIDTH-1:0] pt_cnt;
    logic                 idx_xfer;
    logic                 wr_xfer;
    logic                 last_nbr;
    logic                 last_pt;

    // ==========================================================
    // Handshakes
    // ==========================================================

    assign cfg_rdy     = (state == ST_IDLE);

    // Map index and read address move together
    assign map_rdy     = (state == ST_IDX) & rd_addr_rdy;
    assign rd_addr_vld = (state == ST_IDX) & map_vld;
    assign rd_addr     = cfg_q.rd_base + map_idx;
    assign idx_xfer    = map_vld & map_rdy;

    // One read outstanding, so data is only taken in the data wait
    assign rd_dat_rdy  = (state == ST_DAT);
    assign load_row    = rd_dat_vld & rd_dat_rdy;
    assign first_nbr   = (nbr_cnt == '0);

    assign wr_vld      = (state == ST_WR);
    assign wr.addr     = cfg_q.wr_base + pt_cnt;
    assign wr.dat      = max_row;
    assign wr_xfer     = wr_vld & wr_rdy;

    assign last_nbr    = (nbr_cnt == cfg_q.k - K_WIDTH'(1));
    assign last_pt     = (pt_cnt == cfg_q.nip - IDX_WIDTH'(1));

    // ==========================================================
    // FSM and counters
    // ==========================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            cfg_q   <= '0;
            nbr_cnt <= '0;
            pt_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cfg_vld) begin
                        cfg_q   <= cfg;
                        nbr_cnt <= '0;
                        pt_cnt  <= '0;
                        state   <= ST_IDX;
                    end
                end
                ST_IDX: begin
                    if (idx_xfer) begin
                        state <= ST_DAT;
                    end
                end
                ST_DAT: begin
                    if (load_row) begin
                        if (last_nbr) begin
                            nbr_cnt <= '0;
                            state   <= ST_WR;
                        end else begin
                            nbr_cnt <= nbr_cnt + K_WIDTH'(1);
                            state   <= ST_IDX;
                        end
                    end
                end
                ST_WR: begin
                    // Stalls here while the arbiter holds off the write
                    if (wr_xfer) begin
                        if (last_pt) begin
                            state <= ST_IDLE;
                        end else begin
                            pt_cnt <= pt_cnt + IDX_WIDTH'(1);
                            state  <= ST_IDX;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/pool_pkg.sv
// Max-pooling unit shared definitions
// Widths, core count and the packed payload types

package pool_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================

    // Pooling cores working side by side
    localparam int NUM_CORE       = 2;

    // Activations per feature row
    localparam int LANES          = 8;

    // Unsigned activation width
    localparam int ACT_WIDTH      = 8;

    // Address and index width
    localparam int IDX_WIDTH      = 16;

    // Neighbour count width
    localparam int K_WIDTH        = 5;

    // Core number width
    localparam int CORE_SEL_WIDTH = 1;

    // ==========================================================
    // Payload types
    // ==========================================================

    // One feature row, lane 0 in the low byte
    typedef logic [LANES-1:0][ACT_WIDTH-1:0] act_row_t;

    // Per-core job description
    typedef struct packed {
        logic [IDX_WIDTH-1:0] nip;
        logic [K_WIDTH-1:0]   k;
        logic [IDX_WIDTH-1:0] rd_base;
        logic [IDX_WIDTH-1:0] wr_base;
    } pool_cfg_t;

    // One output row write
    typedef struct packed {
        logic [IDX_WIDTH-1:0] addr;
        act_row_t             dat;
    } ofm_wr_t;

endpackage

// File: source/pool_top.sv
`timescale 1ns/1ps

// Multi-core max-pooling unit
// Two pooling cores with a shared round-robin output write port

module pool_top (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [pool_pkg::NUM_CORE-1:0]                       cfg_vld,
    input  pool_pkg::pool_cfg_t [pool_pkg::NUM_CORE-1:0]        cfg,
    output logic [pool_pkg::NUM_CORE-1:0]                       cfg_rdy,
    input  logic [pool_pkg::NUM_CORE-1:0]                       map_vld,
    input  logic [pool_pkg::NUM_CORE-1:0][pool_pkg::IDX_WIDTH-1:0] map_idx,
    output logic [pool_pkg::NUM_CORE-1:0]                       map_rdy,
    output logic [pool_pkg::NUM_CORE-1:0]                       rd_addr_vld,
    output logic [pool_pkg::NUM_CORE-1:0][pool_pkg::IDX_WIDTH-1:0] rd_addr,
    input  logic [pool_pkg::NUM_CORE-1:0]                       rd_addr_rdy,
    input  logic [pool_pkg::NUM_CORE-1:0]                       rd_dat_vld,
    input  pool_pkg::act_row_t [pool_pkg::NUM_CORE-1:0]         rd_dat,
    output logic [pool_pkg::NUM_CORE-1:0]                       rd_dat_rdy,
    output logic                                                ofm_wr_vld,
    output pool_pkg::ofm_wr_t                                   ofm_wr,
    input  logic                                                ofm_wr_rdy
);
    import pool_pkg::*;

    logic    [NUM_CORE-1:0] core_wr_vld;
    ofm_wr_t [NUM_CORE-1:0] core_wr;
    logic    [NUM_CORE-1:0] core_wr_rdy;

    // ==========================================================
    // Pooling cores
    // ==========================================================

    for (genvar c = 0; c < NUM_CORE; c++) begin : g_core
        pool_core pool_core_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .cfg_vld     (cfg_vld[c]),
            .cfg         (cfg[c]),
            .cfg_rdy     (cfg_rdy[c]),
            .map_vld     (map_vld[c]),
            .map_idx     (map_idx[c]),
            .map_rdy     (map_rdy[c]),
            .rd_addr_vld (rd_addr_vld[c]),
            .rd_addr     (rd_addr[c]),
            .rd_addr_rdy (rd_addr_rdy[c]),
            .rd_dat_vld  (rd_dat_vld[c]),
            .rd_dat      (rd_dat[c]),
            .rd_dat_rdy  (rd_dat_rdy[c]),
            .wr_vld      (core_wr_vld[c]),
            .wr          (core_wr[c]),
            .wr_rdy      (core_wr_rdy[c])
        );
    end

    // Output write merge
    ofm_wr_arbiter ofm_wr_arbiter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_vld    (core_wr_vld),
        .req        (core_wr),
        .req_rdy    (core_wr_rdy),
        .ofm_wr_vld (ofm_wr_vld),
        .ofm_wr     (ofm_wr),
        .ofm_wr_rdy (ofm_wr_rdy)
    );

endmodule

// File: tb/pool_properties.sv
`timescale 1ns/1ps

// Handshake rules on the pooling unit top level

module pool_properties (
    input logic                          clk,
    input logic                          rst_n,
    input logic [pool_pkg::NUM_CORE-1:0] cfg_rdy,
    input logic [pool_pkg::NUM_CORE-1:0] map_vld,
    input logic [pool_pkg::NUM_CORE-1:0] map_rdy,
    input logic [pool_pkg::NUM_CORE-1:0] rd_addr_vld,
    input logic [pool_pkg::NUM_CORE-1:0] rd_dat_rdy,
    input logic                          ofm_wr_vld,
    input pool_pkg::ofm_wr_t             ofm_wr,
    input logic                          ofm_wr_rdy
);

    // Failed assertion count
    int fail_cnt = 0;

    // Stalled output write keeps valid and payload
    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld && !ofm_wr_rdy |=> ofm_wr_vld && $stable(ofm_wr))
        else begin
            $error("stalled output write changed before its transfer");
            fail_cnt++;
        end

    // Read address only offered along with a map index
    a_addr_map: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_addr_vld & ~map_vld) == '0)
        else begin
            $error("read address valid without map valid");
            fail_cnt++;
        end

    a_cfg_dat: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_rdy & rd_dat_rdy) == '0)
        else begin
            $error("core idle and waiting for data at once");
            fail_cnt++;
        end

    // First cycle out of reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> (map_rdy == '0) && (rd_addr_vld == '0)
                         && (rd_dat_rdy == '0) && !ofm_wr_vld)
        else begin
            $error("control output high right after reset");
            fail_cnt++;
        end

endmodule

// File: tb/pool_tb.sv
`timescale 1ns/1ps

// Directed testbench for the multi-core max-pooling unit
// Feature memory model, map feeders and an output write checker

module pool_tb;
    import pool_pkg::*;

    // Neighbours over all tests, sets the cycle limit
    localparam int TOTAL_NBR   = 12 + 4 + 27 + 20 + 10;
    localparam int TIMEOUT_CYC = TOTAL_NBR * 20;
    localparam int MAX_PTS     = 8;
    localparam int MAX_IDX     = 32;

    logic                                clk;
    logic                                rst_n;
    logic [NUM_CORE-1:0]                 cfg_vld;
    pool_cfg_t [NUM_CORE-1:0]            cfg;
    logic [NUM_CORE-1:0]                 cfg_rdy;
    logic [NUM_CORE-1:0]                 map_vld;
    logic [NUM_CORE-1:0][IDX_WIDTH-1:0]  map_idx;
    logic [NUM_CORE-1:0]                 map_rdy;
    logic [NUM_CORE-1:0]                 rd_addr_vld;
    logic [NUM_CORE-1:0][IDX_WIDTH-1:0]  rd_addr;
    logic [NUM_CORE-1:0]                 rd_addr_rdy;
    logic [NUM_CORE-1:0]                 rd_dat_vld;
    act_row_t [NUM_CORE-1:0]             rd_dat;
    logic [NUM_CORE-1:0]                 rd_dat_rdy;
    logic                                ofm_wr_vld;
    ofm_wr_t                             ofm_wr;
    logic                                ofm_wr_rdy;

    logic [IDX_WIDTH-1:0] idx_list [NUM_CORE][0:MAX_IDX-1];
    ofm_wr_t              exp_wr   [NUM_CORE][0:MAX_PTS-1];
    int                   map_ptr  [NUM_CORE];
    int                   map_len  [NUM_CORE];
    int                   exp_head [NUM_CORE];
    int                   exp_len  [NUM_CORE];
    int                   err_cnt;
    int                   wr_cnt;
    int                   cycle_cnt;
    logic                 bp_en;

    pool_top pool_top_inst (.*);

    bind pool_top pool_properties pool_properties_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_rdy     (cfg_rdy),
        .map_vld     (map_vld),
        .map_rdy     (map_rdy),
        .rd_addr_vld (rd_addr_vld),
        .rd_dat_rdy  (rd_dat_rdy),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr      (ofm_wr),
        .ofm_wr_rdy  (ofm_wr_rdy)
    );

    always #5 clk = ~clk;

    // ==========================================================
    // Models and helpers
    // ==========================================================

    // Row contents mix the low and high address bytes per lane
    function automatic act_row_t feature_row(input logic [IDX_WIDTH-1:0] addr);
        act_row_t row;
        for (int l = 0; l < LANES; l++) begin
            row[l] = ACT_WIDTH'(addr[7:0] * 37 + l * 91) ^ addr[15:8];
        end
        return row;
    endfunction

    // All indices taken and all expected writes seen
    function automatic logic jobs_idle();
        logic idle;
        idle = 1'b1;
        for (int c = 0; c < NUM_CORE; c++) begin
            if (exp_head[c] != exp_len[c] || map_ptr[c] != map_len[c]) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    task automatic report_counts();
        $display("Summary: %0d writes checked, %0d errors, %0d assertion failures",
                 wr_cnt, err_cnt, pool_top_inst.pool_properties_inst.fail_cnt);
    endtask

    // One read in flight, answered after a random delay
    task automatic serve_reads(input int c);
        logic [IDX_WIDTH-1:0] addr;
        forever begin
            @(posedge clk);
            if (rd_addr_vld[c] && rd_addr_rdy[c]) begin
                addr = rd_addr[c];
                @(negedge clk);
                repeat ($urandom_range(2, 0)) @(negedge clk);
                rd_dat_vld[c] = 1'b1;
                rd_dat[c]     = feature_row(addr);
                @(posedge clk);
                while (!rd_dat_rdy[c]) @(posedge clk);
                @(negedge clk);
                rd_dat_vld[c] = 1'b0;
            end
        end
    endtask

    task automatic feed_map(input int c);
        forever begin
            @(negedge clk);
            if (map_ptr[c] < map_len[c]) begin
                map_vld[c] = 1'b1;
                map_idx[c] = idx_list[c][map_ptr[c]];
                @(posedge clk);
                while (!map_rdy[c]) @(posedge clk);
                map_ptr[c]++;
            end else begin
                map_vld[c] = 1'b0;
            end
        end
    endtask

    for (genvar c = 0; c < NUM_CORE; c++) begin : g_agent
        initial serve_reads(c);
        initial feed_map(c);
    end

    // Builds the index list and expected writes, then hands over the config
    task automatic start_job(input int c, input int nip, input int k,
                             input logic [IDX_WIDTH-1:0] rd_base,
                             input logic [IDX_WIDTH-1:0] wr_base);
        pool_cfg_t            job;
        logic [IDX_WIDTH-1:0] idx;
        act_row_t             row;
        act_row_t             best;
        @(negedge clk);
        while (!cfg_rdy[c]) @(negedge clk);
        for (int p = 0; p < nip; p++) begin
            best = '0;
            for (int n = 0; n < k; n++) begin
                idx = IDX_WIDTH'($urandom_range(255, 0));
                idx_list[c][p * k + n] = idx;
                row = feature_row(rd_base + idx);
                for (int l = 0; l < LANES; l++) begin
                    if (row[l] > best[l]) begin
                        best[l] = row[l];
                    end
                end
            end
            exp_wr[c][p].addr = wr_base + IDX_WIDTH'(p);
            exp_wr[c][p].dat  = best;
        end
        map_ptr[c]  = 0;
        map_len[c]  = nip * k;
        exp_head[c] = 0;
        exp_len[c]  = nip;
        job.nip     = IDX_WIDTH'(nip);
        job.k       = K_WIDTH'(k);
        job.rd_base = rd_base;
        job.wr_base = wr_base;
        cfg_vld[c]  = 1'b1;
        cfg[c]      = job;
        @(posedge clk);
        @(negedge clk);
        cfg_vld[c] = 1'b0;
    endtask

    task automatic wait_done();
        do @(negedge clk); while (!jobs_idle());
    endtask

    // ==========================================================
    // Output write checker
    // ==========================================================

    // Each write must be the next expected point of some core
    always @(posedge clk) begin : check_writes
        int      hit;
        ofm_wr_t exp;
        hit = -1;
        if (rst_n && ofm_wr_vld && ofm_wr_rdy) begin
            wr_cnt++;
            for (int c = 0; c < NUM_CORE; c++) begin
                if (hit < 0 && exp_head[c] < exp_len[c]
                        && exp_wr[c][exp_head[c]].addr == ofm_wr.addr) begin
                    hit = c;
                end
            end
            if (hit < 0) begin
                err_cnt++;
                $display("[ERROR] ofm_wr.addr: got %h, not the next point of any core",
                         ofm_wr.addr);
            end else begin
                exp = exp_wr[hit][exp_head[hit]];
                if (ofm_wr.dat !== exp.dat) begin
                    err_cnt++;
                    $display("[ERROR] ofm_wr.dat core %0d addr %h: got %h expected %h",
                             hit, exp.addr, ofm_wr.dat, exp.dat);
                end
                exp_head[hit]++;
            end
        end
    end

    always @(negedge clk) begin
        ofm_wr_rdy = bp_en ? 1'($urandom_range(1, 0)) : 1'b1;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYC) begin
            $display("Timeout: writes still missing after %0d cycles", TIMEOUT_CYC);
            report_counts();
            $display(">>> FAIL");
            $finish;
        end
    end

    // ==========================================================
    // Tests
    // ==========================================================

    task automatic single_core_pool();
        start_job(0, 3, 4, 16'h0100, 16'h0040);
        wait_done();
    endtask

    task automatic single_neighbour_pool();
        start_job(1, 4, 1, 16'h0800, 16'h0080);
        wait_done();
    endtask

    task automatic dual_core_pool();
        start_job(0, 4, 3, 16'h0200, 16'h0100);
        start_job(1, 3, 5, 16'hff80, 16'h0200);
        wait_done();
    endtask

    task automatic stalled_write_pool();
        bp_en = 1'b1;
        start_job(0, 5, 2, 16'h1000, 16'h0300);
        start_job(1, 5, 2, 16'h2000, 16'h0400);
        wait_done();
        bp_en = 1'b0;
    endtask

    task automatic idle_return_pool();
        start_job(1, 2, 3, 16'h0400, 16'h0500);
        wait_done();
        if (cfg_rdy[1] !== 1'b1) begin
            err_cnt++;
            $display("[ERROR] cfg_rdy[1]: got %h expected 1", cfg_rdy[1]);
        end
        start_job(1, 2, 2, 16'h0c00, 16'h0600);
        wait_done();
    endtask

    initial begin
        void'($urandom(32'h3718_55ae));
        clk         = 1'b0;
        rst_n       = 1'b0;
        cfg_vld     = '0;
        cfg         = '0;
        map_vld     = '0;
        map_idx     = '0;
        rd_addr_rdy = '0;
        rd_dat_vld  = '0;
        rd_dat      = '0;
        ofm_wr_rdy  = 1'b0;
        bp_en       = 1'b0;
        err_cnt     = 0;
        wr_cnt      = 0;
        cycle_cnt   = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n       = 1'b1;
        rd_addr_rdy = '1;

        single_core_pool();
        single_neighbour_pool();
        dual_core_pool();
        stalled_write_pool();
        idle_return_pool();

        report_counts();
        if (err_cnt == 0 && pool_top_inst.pool_properties_inst.fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/pool_pkg.sv
source/pool_ctrl.sv
source/max_array.sv
source/pool_core.sv
source/ofm_wr_arbiter.sv
source/pool_top.sv
tb/pool_properties.sv
tb/pool_tb.sv
